// File: hw/mmio_settings.svh
`ifndef MMIO_SETTINGS_SVH
`define MMIO_SETTINGS_SVH

// bus width in bits
`define BUS_W 32

// memory map
`define UART_TX_ADDR 32'h1000_0000
`define UART_RX_BASE 32'h1000_0010
`define UART_RX_END  32'h1000_001F
`define CLINT_BASE   32'h0200_0000
`define CLINT_END    32'h0200_000F

// serial timing kept small for simulation
`define UART_CLKS_PER_BIT 8

// receive fifo
`define UART_RX_DEPTH 4
`define UART_RX_CNT_W 3

`endif

// File: hw/mmio_pkg.sv
`include "mmio_settings.svh"

package mmio_pkg;

    // ####################
    // bus vectors
    // ####################
    typedef logic [`BUS_W-1:0]   addr_t;     // byte address
    typedef logic [`BUS_W-1:0]   data_t;
    typedef logic [`BUS_W/8-1:0] wmask_t;    // one enable per byte
    typedef logic [7:0]          uart_byte_t;
    typedef logic [63:0]         mtime_t;

    // ####################
    // state machines
    // ####################
    typedef enum logic [1:0] {
        cntr_idle,
        cntr_wait_ready,  // request latched until the target is ready
        cntr_wait_valid   // request issued and response outstanding
    } cntr_state_t;

    typedef enum logic [1:0] {
        uart_idle,
        uart_start,
        uart_data,
        uart_stop
    } uart_state_t;

endpackage

// File: hw/uart_tx.sv
`include "mmio_settings.svh"

module uart_tx import mmio_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  req_valid,
    input  logic  req_wen,
    input  data_t req_wdata,
    output logic  req_ready,
    output logic  resp_valid,
    output data_t resp_rdata,
    output logic  txd
);

    localparam int div_w = $clog2(`UART_CLKS_PER_BIT);

    uart_state_t      state;
    logic [div_w-1:0] div_cnt;
    logic [2:0]       bit_idx;
    uart_byte_t       shift;
    logic             busy;
    logic             bit_end;

    assign busy      = state != uart_idle;
    assign bit_end   = div_cnt == div_w'(`UART_CLKS_PER_BIT - 1);
    assign req_ready = !busy || !req_wen;  // status reads never stall

    always_ff @(posedge clk) begin
        resp_rdata <= data_t'(busy);
        if (req_valid && req_wen && !busy) shift <= req_wdata[7:0];
        else if (state == uart_data && bit_end) shift <= shift >> 1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= uart_idle;
            div_cnt    <= '0;
            bit_idx    <= '0;
            txd        <= 1'b1;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_valid && req_ready;
            div_cnt    <= (state == uart_idle || bit_end) ? '0 : div_cnt + 1'b1;
            case (state)
                uart_idle: begin
                    txd <= 1'b1;
                    if (req_valid && req_wen) state <= uart_start;
                end
                uart_start: begin
                    txd <= 1'b0;
                    bit_idx <= '0;
                    if (bit_end) state <= uart_data;
                end
                uart_data: begin
                    txd <= shift[0];  // lsb first
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= uart_stop;
                    end
                end
                default: begin
                    txd <= 1'b1;
                    if (bit_end) state <= uart_idle;
                end
            endcase
        end
    end

endmodule

// File: hw/uart_rx.sv
`include "mmio_settings.svh"

module uart_rx import mmio_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       rxd,
    input  logic       req_valid,
    input  logic [3:0] req_addr,
    input  logic       req_wen,
    output logic       req_ready,
    output logic       resp_valid,
    output data_t      resp_rdata,
    output logic       uart_rx_pending
);

    localparam int div_w = $clog2(`UART_CLKS_PER_BIT);
    localparam int ptr_w = $clog2(`UART_RX_DEPTH);

    logic                     rxd_meta, rxd_sync;
    uart_state_t              state;
    logic [div_w-1:0]         div_cnt;
    logic [2:0]               bit_idx;
    uart_byte_t               shift;
    uart_byte_t               fifo [`UART_RX_DEPTH];
    logic [ptr_w-1:0]         wr_ptr, rd_ptr;
    logic [`UART_RX_CNT_W-1:0] count;
    logic                     half_end, bit_end, push, pop, full;

    assign half_end = div_cnt == div_w'(`UART_CLKS_PER_BIT / 2 - 1);
    assign bit_end  = div_cnt == div_w'(`UART_CLKS_PER_BIT - 1);
    assign full     = count == `UART_RX_CNT_W'(`UART_RX_DEPTH);
    assign push     = state == uart_stop && bit_end && rxd_sync && !full;  // full drops the byte
    assign pop      = req_valid && !req_wen && req_addr == 4'h0 && count != '0;

    assign req_ready       = 1'b1;
    assign uart_rx_pending = count != '0;

    always_ff @(posedge clk) begin
        if (push) fifo[wr_ptr] <= shift;
        if (state == uart_data && bit_end) shift <= {rxd_sync, shift[7:1]};
        case (req_addr)
            4'h0:    resp_rdata <= (count != '0) ? data_t'(fifo[rd_ptr]) : '0;
            4'h4:    resp_rdata <= data_t'(count);
            default: resp_rdata <= '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            {rxd_meta, rxd_sync} <= 2'b11;
            state      <= uart_idle;
            div_cnt    <= '0;
            bit_idx    <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            resp_valid <= 1'b0;
        end else begin
            {rxd_meta, rxd_sync} <= {rxd, rxd_meta};
            resp_valid <= req_valid;
            div_cnt    <= (state == uart_idle || bit_end) ? '0 : div_cnt + 1'b1;
            case (state)
                uart_idle:  if (!rxd_sync) state <= uart_start;
                uart_start: if (half_end) begin
                    div_cnt <= '0;  // realign to mid-bit
                    bit_idx <= '0;
                    state   <= rxd_sync ? uart_idle : uart_data;  // a glitch is not a start bit
                end
                uart_data: if (bit_end) begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= uart_stop;
                end
                default: if (bit_end) state <= uart_idle;
            endcase
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + `UART_RX_CNT_W'(push) - `UART_RX_CNT_W'(pop);
        end
    end

endmodule

// File: hw/clint.sv
`include "mmio_settings.svh"

module clint import mmio_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       req_valid,
    input  logic [3:0] req_addr,
    input  logic       req_wen,
    input  data_t      req_wdata,
    input  mtime_t     mtime,
    output logic       req_ready,
    output logic       resp_valid,
    output data_t      resp_rdata,
    output mtime_t     mtimecmp,
    output logic       timer_irq
);

    logic wr_lo, wr_hi;

    assign req_ready = 1'b1;
    assign wr_lo     = req_valid && req_wen && req_addr == 4'h0;
    assign wr_hi     = req_valid && req_wen && req_addr == 4'h4;

    // mtime halves are read only
    always_ff @(posedge clk) begin
        case (req_addr)
            4'h0:    resp_rdata <= mtimecmp[31:0];
            4'h4:    resp_rdata <= mtimecmp[63:32];
            4'h8:    resp_rdata <= mtime[31:0];
            4'hc:    resp_rdata <= mtime[63:32];
            default: resp_rdata <= '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mtimecmp   <= '1;  // no interrupt until software sets it
            resp_valid <= 1'b0;
            timer_irq  <= 1'b0;
        end else begin
            resp_valid <= req_valid;
            timer_irq  <= mtime >= mtimecmp;
            if (wr_lo) mtimecmp[31:0] <= req_wdata;
            if (wr_hi) mtimecmp[63:32] <= req_wdata;
        end
    end

endmodule

// File: hw/mmio_cntr.sv
`include "mmio_settings.svh"

module mmio_cntr import mmio_pkg::*; (
    input  logic   clk,
    input  logic   reset,

    input  logic   dreq_valid,
    output logic   dreq_ready,
    input  addr_t  dreq_addr,
    input  logic   dreq_wen,
    input  data_t  dreq_wdata,
    input  wmask_t dreq_wmask,
    output logic   dresp_valid,
    output data_t  dresp_rdata,
    output logic   dresp_error,

    output logic   mem_req_valid,
    input  logic   mem_req_ready,
    output addr_t  mem_req_addr,
    output logic   mem_req_wen,
    output data_t  mem_req_wdata,
    output wmask_t mem_req_wmask,
    input  logic   mem_resp_valid,
    input  data_t  mem_resp_rdata,
    input  logic   mem_resp_error,

    input  logic   rxd,
    output logic   txd,
    input  mtime_t mtime,
    output mtime_t mtimecmp,
    output logic   timer_irq,
    output logic   uart_rx_pending
);

    function automatic logic in_range(input addr_t a, input addr_t lo, input addr_t hi);
        return a >= lo && a <= hi;
    endfunction

    cntr_state_t state;
    addr_t       s_addr;
    logic        s_wen;
    data_t       s_wdata;
    wmask_t      s_wmask;

    logic  tx_ready, tx_rvalid, rx_ready, rx_rvalid, clint_ready, clint_rvalid;
    data_t tx_rdata, rx_rdata, clint_rdata;

    // ####################
    // address decode
    // ####################
    logic is_uart_tx, is_uart_rx, is_clint, is_memory;
    logic s_is_uart_tx, s_is_uart_rx, s_is_clint, s_is_memory;
    logic c_is_uart_tx, c_is_uart_rx, c_is_clint, c_is_memory;

    assign is_uart_tx = dreq_addr == `UART_TX_ADDR;  // live request
    assign is_uart_rx = in_range(dreq_addr, `UART_RX_BASE, `UART_RX_END);
    assign is_clint   = in_range(dreq_addr, `CLINT_BASE, `CLINT_END);
    assign is_memory  = !is_uart_tx && !is_uart_rx && !is_clint;

    assign s_is_uart_tx = s_addr == `UART_TX_ADDR;  // latched request
    assign s_is_uart_rx = in_range(s_addr, `UART_RX_BASE, `UART_RX_END);
    assign s_is_clint   = in_range(s_addr, `CLINT_BASE, `CLINT_END);
    assign s_is_memory  = !s_is_uart_tx && !s_is_uart_rx && !s_is_clint;

    // target of the request on the bus this cycle
    assign c_is_uart_tx = (state == cntr_wait_ready) ? s_is_uart_tx : is_uart_tx;
    assign c_is_uart_rx = (state == cntr_wait_ready) ? s_is_uart_rx : is_uart_rx;
    assign c_is_clint   = (state == cntr_wait_ready) ? s_is_clint   : is_clint;
    assign c_is_memory  = (state == cntr_wait_ready) ? s_is_memory  : is_memory;

    // ####################
    // handshake
    // ####################
    logic   resp_done, cmd_start, cmd_ready;
    addr_t  req_addr;
    logic   req_wen;
    data_t  req_wdata;

    assign resp_done = state == cntr_wait_valid && (
                           (s_is_memory  && mem_resp_valid) ||
                           (s_is_uart_tx && tx_rvalid) ||
                           (s_is_uart_rx && rx_rvalid) ||
                           (s_is_clint   && clint_rvalid));

    assign dreq_ready = state == cntr_idle || resp_done;
    assign cmd_start  = state == cntr_wait_ready || (dreq_ready && dreq_valid);
    assign cmd_ready  = c_is_uart_tx ? tx_ready :
                        c_is_uart_rx ? rx_ready :
                        c_is_clint   ? clint_ready : mem_req_ready;

    assign req_addr  = (state == cntr_wait_ready) ? s_addr  : dreq_addr;
    assign req_wen   = (state == cntr_wait_ready) ? s_wen   : dreq_wen;
    assign req_wdata = (state == cntr_wait_ready) ? s_wdata : dreq_wdata;

    assign mem_req_valid = c_is_memory && cmd_start;
    assign mem_req_addr  = req_addr;
    assign mem_req_wen   = req_wen;
    assign mem_req_wdata = req_wdata;
    assign mem_req_wmask = (state == cntr_wait_ready) ? s_wmask : dreq_wmask;

    assign dresp_valid = resp_done;
    assign dresp_rdata = s_is_memory  ? mem_resp_rdata :
                         s_is_uart_tx ? tx_rdata :
                         s_is_uart_rx ? rx_rdata : clint_rdata;
    assign dresp_error = s_is_memory && mem_resp_error;  // peripherals never fault

    always_ff @(posedge clk) begin
        if (dreq_valid && dreq_ready) begin
            s_addr  <= dreq_addr;
            s_wen   <= dreq_wen;
            s_wdata <= dreq_wdata;
            s_wmask <= dreq_wmask;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cntr_idle;
        end else begin
            case (state)
                cntr_idle: if (dreq_valid) state <= cmd_ready ? cntr_wait_valid : cntr_wait_ready;
                cntr_wait_ready: if (cmd_ready) state <= cntr_wait_valid;
                cntr_wait_valid: if (resp_done) begin
                    if (dreq_valid) state <= cmd_ready ? cntr_wait_valid : cntr_wait_ready;
                    else state <= cntr_idle;
                end
                default: state <= cntr_idle;
            endcase
        end
    end

    // ####################
    // peripherals
    // ####################
    uart_tx u_uart_tx (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (c_is_uart_tx && cmd_start),
        .req_wen    (req_wen),
        .req_wdata  (req_wdata),
        .req_ready  (tx_ready),
        .resp_valid (tx_rvalid),
        .resp_rdata (tx_rdata),
        .txd        (txd)
    );

    uart_rx u_uart_rx (
        .clk             (clk),
        .reset           (reset),
        .rxd             (rxd),
        .req_valid       (c_is_uart_rx && cmd_start),
        .req_addr        (req_addr[3:0]),
        .req_wen         (req_wen),
        .req_ready       (rx_ready),
        .resp_valid      (rx_rvalid),
        .resp_rdata      (rx_rdata),
        .uart_rx_pending (uart_rx_pending)
    );

    clint u_clint (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (c_is_clint && cmd_start),
        .req_addr   (req_addr[3:0]),
        .req_wen    (req_wen),
        .req_wdata  (req_wdata),
        .mtime      (mtime),
        .req_ready  (clint_ready),
        .resp_valid (clint_rvalid),
        .resp_rdata (clint_rdata),
        .mtimecmp   (mtimecmp),
        .timer_irq  (timer_irq)
    );

endmodule

// File: hw/mmio_system.sv
module mmio_system import mmio_pkg::*; (
    input  logic   clk,
    input  logic   reset,

    // core data port
    input  logic   dreq_valid,
    output logic   dreq_ready,
    input  addr_t  dreq_addr,
    input  logic   dreq_wen,
    input  data_t  dreq_wdata,
    input  wmask_t dreq_wmask,
    output logic   dresp_valid,
    output data_t  dresp_rdata,
    output logic   dresp_error,

    // external memory
    output logic   mem_req_valid,
    input  logic   mem_req_ready,
    output addr_t  mem_req_addr,
    output logic   mem_req_wen,
    output data_t  mem_req_wdata,
    output wmask_t mem_req_wmask,
    input  logic   mem_resp_valid,
    input  data_t  mem_resp_rdata,
    input  logic   mem_resp_error,

    // serial and timer
    input  logic   rxd,
    output logic   txd,
    input  mtime_t mtime,
    output mtime_t mtimecmp,
    output logic   timer_irq,
    output logic   uart_rx_pending
);

    mmio_cntr u_mmio_cntr (
        .clk             (clk),
        .reset           (reset),
        .dreq_valid      (dreq_valid),
        .dreq_ready      (dreq_ready),
        .dreq_addr       (dreq_addr),
        .dreq_wen        (dreq_wen),
        .dreq_wdata      (dreq_wdata),
        .dreq_wmask      (dreq_wmask),
        .dresp_valid     (dresp_valid),
        .dresp_rdata     (dresp_rdata),
        .dresp_error     (dresp_error),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_req_addr    (mem_req_addr),
        .mem_req_wen     (mem_req_wen),
        .mem_req_wdata   (mem_req_wdata),
        .mem_req_wmask   (mem_req_wmask),
        .mem_resp_valid  (mem_resp_valid),
        .mem_resp_rdata  (mem_resp_rdata),
        .mem_resp_error  (mem_resp_error),
        .rxd             (rxd),
        .txd             (txd),
        .mtime           (mtime),
        .mtimecmp        (mtimecmp),
        .timer_irq       (timer_irq),
        .uart_rx_pending (uart_rx_pending)
    );

endmodule

// File: sim/mmio_system_tb.sv
`include "mmio_settings.svh"

module mmio_system_tb import mmio_pkg::*; ();

    localparam int clks = `UART_CLKS_PER_BIT;

    logic   clk, reset;
    logic   dreq_valid, dreq_ready, dreq_wen;
    addr_t  dreq_addr;
    data_t  dreq_wdata;
    wmask_t dreq_wmask;
    logic   dresp_valid, dresp_error;
    data_t  dresp_rdata;
    logic   mem_req_valid, mem_req_ready, mem_req_wen;
    addr_t  mem_req_addr;
    data_t  mem_req_wdata;
    wmask_t mem_req_wmask;
    logic   mem_resp_valid, mem_resp_error;
    data_t  mem_resp_rdata;
    logic   rxd, txd, timer_irq, uart_rx_pending;
    mtime_t mtime, mtimecmp;

    int     errors, timeouts, cyc;
    logic   mem_stall, err_inject;
    data_t  mem_model [256];
    addr_t  last_addr;  // fields of the last accepted memory request
    logic   last_wen;
    data_t  last_wdata;
    wmask_t last_wmask;
    int     resp_due[$];
    data_t  resp_data[$];
    logic   resp_err[$];

    mmio_system uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ####################
    // memory model
    // ####################
    initial begin : memory_model
        int lat;
        int due;
        int last_due;
        cyc            = 0;
        last_due       = 0;
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_rdata = '0;
        mem_resp_error = 1'b0;
        for (int i = 0; i < 256; i++)
            mem_model[i] = (32'h8000_0000 + data_t'(i * 4)) ^ 32'h0f0f_5a5a;
        forever begin
            @(negedge clk);
            if (!reset && mem_req_valid && mem_req_ready) begin  // transfers on the next edge
                last_addr  = mem_req_addr;
                last_wen   = mem_req_wen;
                last_wdata = mem_req_wdata;
                last_wmask = mem_req_wmask;
                if (mem_req_wen)
                    for (int b = 0; b < 4; b++)
                        if (mem_req_wmask[b])
                            mem_model[mem_req_addr[9:2]][8*b +: 8] = mem_req_wdata[8*b +: 8];
                lat = $urandom_range(1, 4);
                due = cyc + lat;
                if (due <= last_due) due = last_due + 1;  // keep responses in order
                last_due = due;
                resp_due.push_back(due);
                resp_data.push_back(mem_model[mem_req_addr[9:2]]);
                resp_err.push_back(err_inject);
            end
            @(posedge clk);
            cyc++;
            #10;
            mem_req_ready  = !mem_stall && $urandom_range(0, 3) != 0;
            mem_resp_valid = 1'b0;
            mem_resp_rdata = '0;
            mem_resp_error = 1'b0;
            if (resp_due.size() > 0 && resp_due[0] <= cyc) begin
                mem_resp_valid = 1'b1;
                mem_resp_rdata = resp_data.pop_front();
                mem_resp_error = resp_err.pop_front();
                void'(resp_due.pop_front());
            end
        end
    end

    // ####################
    // checks
    // ####################
    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_time(input mtime_t got, input mtime_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input wmask_t m);
        data_t r;
        r = old_w;
        for (int b = 0; b < 4; b++)
            if (m[b]) r[8*b +: 8] = new_w[8*b +: 8];
        return r;
    endfunction

    // ####################
    // bus and serial tasks
    // ####################
    task automatic do_access(input addr_t addr, input logic wen, input data_t wdata,
                             input wmask_t wmask, output data_t rdata, output logic err,
                             output int lat);
        int n;
        @(posedge clk);
        #10;
        dreq_valid = 1'b1;
        dreq_addr  = addr;
        dreq_wen   = wen;
        dreq_wdata = wdata;
        dreq_wmask = wmask;
        n = 0;
        @(negedge clk);
        while (!dreq_ready && n < 100) begin
            n++;
            @(negedge clk);
        end
        if (!dreq_ready) report_timeout("dreq_ready");
        @(posedge clk);
        #10;
        dreq_valid = 1'b0;
        rdata = '0;
        err   = 1'b0;
        lat   = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!dresp_valid && lat < 100);
        if (dresp_valid) begin
            rdata = dresp_rdata;
            err   = dresp_error;
        end else begin
            report_timeout("dresp_valid");
        end
    endtask

    task automatic write_word(input addr_t addr, input data_t wdata, input wmask_t wmask);
        data_t d;
        logic  e;
        int    lat;
        do_access(addr, 1'b1, wdata, wmask, d, e, lat);
    endtask

    task automatic read_word(input addr_t addr, output data_t rdata);
        logic e;
        int   lat;
        do_access(addr, 1'b0, '0, '0, rdata, e, lat);
    endtask

    task automatic send_serial(input uart_byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};  // start bit then data lsb first
        @(posedge clk);
        #10;
        for (int i = 0; i < 10; i++) begin
            rxd = frame[i];
            repeat (clks) @(posedge clk);
            #10;
        end
    endtask

    task automatic recv_serial(output uart_byte_t b);
        int n;
        n = 0;
        b = '0;
        @(negedge clk);
        while (txd && n < 40 * clks) begin
            n++;
            @(negedge clk);
        end
        if (txd) report_timeout("start bit on txd");
        repeat (clks / 2) @(negedge clk);  // move to the bit centre
        check_bit(txd, 1'b0, "txd start bit");
        for (int i = 0; i < 8; i++) begin
            repeat (clks) @(negedge clk);
            b[i] = txd;
        end
        repeat (clks) @(negedge clk);
        check_bit(txd, 1'b1, "txd stop bit");
    endtask

    // ####################
    // tests
    // ####################
    task automatic memory_passthrough();
        addr_t  a;
        data_t  w1, w2, d;
        wmask_t m;
        logic   e;
        int     lat;
        for (int i = 0; i < 6; i++) begin
            a  = 32'h8000_0000 | addr_t'($urandom_range(0, 255) << 2);
            w1 = $urandom();
            w2 = $urandom();
            m  = wmask_t'($urandom_range(1, 15));
            do_access(a, 1'b1, w1, 4'hf, d, e, lat);
            do_access(a, 1'b1, w2, m, d, e, lat);
            check_data(last_addr, a, "mem_req_addr");
            check_bit(last_wen, 1'b1, "mem_req_wen on write");
            check_data(last_wdata, w2, "mem_req_wdata");
            check_data(data_t'(last_wmask), data_t'(m), "mem_req_wmask");
            do_access(a, 1'b0, '0, '0, d, e, lat);
            check_bit(last_wen, 1'b0, "mem_req_wen on read");
            check_data(d, merge_bytes(w1, w2, m), "masked read data");
            check_bit(e, 1'b0, "dresp_error");
        end
        err_inject = 1'b1;
        do_access(a, 1'b0, '0, '0, d, e, lat);
        err_inject = 1'b0;
        check_bit(e, 1'b1, "injected dresp_error");
    endtask

    task automatic transmit_frame();
        uart_byte_t b, got;
        data_t      d;
        b = uart_byte_t'($urandom());
        write_word(`UART_TX_ADDR, data_t'(b), 4'h1);
        fork
            recv_serial(got);
            begin
                repeat (3 * clks) @(posedge clk);
                read_word(`UART_TX_ADDR, d);
                check_data(d, 32'd1, "uart busy during frame");
            end
        join
        check_byte(got, b, "byte on txd");
        repeat (2 * clks) @(posedge clk);
        read_word(`UART_TX_ADDR, d);
        check_data(d, 32'd0, "uart busy after frame");
    endtask

    task automatic receive_fifo();
        uart_byte_t bytes [5];
        data_t      d;
        int         n;
        for (int i = 0; i < 5; i++) bytes[i] = uart_byte_t'($urandom());
        for (int i = 0; i < 3; i++) send_serial(bytes[i]);
        n = 0;
        @(negedge clk);
        while (!uart_rx_pending && n < 100) begin
            n++;
            @(negedge clk);
        end
        check_bit(uart_rx_pending, 1'b1, "uart_rx_pending after three bytes");
        read_word(`UART_RX_BASE + 4, d);
        check_data(d, 32'd3, "fifo count");
        for (int i = 0; i < 3; i++) begin
            read_word(`UART_RX_BASE, d);
            check_data(d, data_t'(bytes[i]), "fifo pop");
        end
        check_bit(uart_rx_pending, 1'b0, "uart_rx_pending when empty");
        read_word(`UART_RX_BASE, d);
        check_data(d, 32'd0, "pop of empty fifo");
        for (int i = 0; i < 5; i++) bytes[i] = uart_byte_t'($urandom());
        for (int i = 0; i < 5; i++) send_serial(bytes[i]);  // last one finds the fifo full
        read_word(`UART_RX_BASE + 4, d);
        check_data(d, 32'd4, "fifo count when full");
        for (int i = 0; i < 4; i++) begin
            read_word(`UART_RX_BASE, d);
            check_data(d, data_t'(bytes[i]), "fifo pop after overflow");
        end
        read_word(`UART_RX_BASE, d);
        check_data(d, 32'd0, "dropped byte");
    endtask

    task automatic timer_compare();
        data_t d;
        int    n;
        read_word(`CLINT_BASE, d);
        check_data(d, 32'hffff_ffff, "mtimecmp low after reset");
        read_word(`CLINT_BASE + 4, d);
        check_data(d, 32'hffff_ffff, "mtimecmp high after reset");
        check_time(mtimecmp, '1, "mtimecmp port after reset");
        @(posedge clk);
        #10;
        mtime = 64'h1234_5678_9abc_def0;
        read_word(`CLINT_BASE + 8, d);
        check_data(d, 32'h9abc_def0, "mtime low");
        read_word(`CLINT_BASE + 12, d);
        check_data(d, 32'h1234_5678, "mtime high");
        check_bit(timer_irq, 1'b0, "timer_irq below mtimecmp");
        @(posedge clk);
        #10;
        mtime = 64'h0000_0001_0000_0000;
        write_word(`CLINT_BASE, 32'h0000_0100, 4'hf);
        write_word(`CLINT_BASE + 4, 32'h0000_0001, 4'hf);
        read_word(`CLINT_BASE, d);
        check_data(d, 32'h0000_0100, "mtimecmp low readback");
        read_word(`CLINT_BASE + 4, d);
        check_data(d, 32'h0000_0001, "mtimecmp high readback");
        check_time(mtimecmp, 64'h0000_0001_0000_0100, "mtimecmp port");
        repeat (3) @(negedge clk);
        check_bit(timer_irq, 1'b0, "timer_irq before match");
        @(posedge clk);
        #10;
        mtime = 64'h0000_0001_0000_0100;
        n = 0;
        @(negedge clk);
        while (!timer_irq && n < 10) begin
            n++;
            @(negedge clk);
        end
        check_bit(timer_irq, 1'b1, "timer_irq at mtimecmp");
    endtask

    task automatic stall_and_overlap();
        addr_t a0, a1;
        data_t v0, v1, d;
        logic  e;
        int    lat, n, m;
        addr_t addrs [6];
        data_t expect_v [6];
        data_t got_q[$];
        a0 = 32'h8000_0100;
        a1 = 32'h8000_0204;
        v0 = $urandom();
        v1 = $urandom();
        write_word(a0, v0, 4'hf);
        write_word(a1, v1, 4'hf);
        mem_stall = 1'b1;
        @(posedge clk);
        #10;
        mtime     = 64'h0000_0002_dead_beef;
        @(posedge clk);
        #10;
        dreq_valid = 1'b1;
        dreq_addr  = a0;
        dreq_wen   = 1'b0;
        @(negedge clk);
        check_bit(dreq_ready, 1'b1, "dreq_ready in idle");
        @(posedge clk);
        #10;
        dreq_valid = 1'b0;
        dreq_addr  = a1;  // the held request must not follow the core
        repeat (5) begin
            @(negedge clk);
            check_bit(dreq_ready, 1'b0, "dreq_ready under back-pressure");
            check_bit(mem_req_valid, 1'b1, "held mem_req_valid");
            check_data(mem_req_addr, a0, "held mem_req_addr");
            check_bit(mem_req_wen, 1'b0, "held mem_req_wen");
        end
        mem_stall = 1'b0;
        n = 0;
        while (!dresp_valid && n < 50) begin
            n++;
            @(negedge clk);
        end
        if (!dresp_valid) report_timeout("response after back-pressure");
        check_data(dresp_rdata, v0, "read data after back-pressure");
        do_access(`CLINT_BASE, 1'b0, '0, '0, d, e, lat);
        check_bit(lat == 1, 1'b1, "clint response one cycle after acceptance");
        addrs    = '{a0, `CLINT_BASE, a1, `CLINT_BASE + 8, a0, `CLINT_BASE + 4};
        expect_v = '{v0, 32'h0000_0100, v1, 32'hdead_beef, v0, 32'h0000_0001};
        fork
            begin
                @(posedge clk);
                #10;
                foreach (addrs[i]) begin
                    dreq_valid = 1'b1;
                    dreq_addr  = addrs[i];
                    dreq_wen   = 1'b0;
                    n = 0;
                    @(negedge clk);
                    while (!dreq_ready && n < 100) begin
                        n++;
                        @(negedge clk);
                    end
                    if (!dreq_ready) report_timeout("dreq_ready in back-to-back run");
                    if (i > 0) check_bit(dresp_valid, 1'b1, "request taken with the previous response");
                    @(posedge clk);
                    #10;
                end
                dreq_valid = 1'b0;
            end
            begin
                m = 0;
                while (got_q.size() < 6 && m < 400) begin
                    @(negedge clk);
                    m++;
                    if (dresp_valid) got_q.push_back(dresp_rdata);
                end
                if (got_q.size() < 6) report_timeout("back-to-back responses");
            end
        join
        foreach (expect_v[i]) check_data(got_q[i], expect_v[i], "back-to-back response");
    endtask

    initial begin
        void'($urandom(3769));
        errors     = 0;
        timeouts   = 0;
        reset      = 1'b1;
        dreq_valid = 1'b0;
        dreq_addr  = '0;
        dreq_wen   = 1'b0;
        dreq_wdata = '0;
        dreq_wmask = '0;
        rxd        = 1'b1;
        mtime      = '0;
        mem_stall  = 1'b0;
        err_inject = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;

        memory_passthrough();
        transmit_frame();
        receive_fifo();
        timer_compare();
        stall_and_overlap();

        $display("errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: mmio_system.f
+incdir+hw
hw/mmio_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/clint.sv
hw/mmio_cntr.sv
hw/mmio_system.sv
sim/mmio_system_tb.sv

// File: Makefile
# Verilator build and run for mmio_system

VERILATOR ?= verilator
TOP       ?= mmio_system_tb
FILELIST  ?= mmio_system.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) hw/mmio_settings.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
